// ==== design/icache_cfg_pkg.sv ====
/*
 * Cache geometry and datapath widths shared by the design.
 * Fetch address and word are fixed at 32 bits and one line is one 128-bit refill beat.
 * Tags are full width. The sets and ways defaults can be overridden at the top level.
 */

package icache_cfg_pkg;

   //////////////////////////////////////////////////////////
   // Datapath types
   //////////////////////////////////////////////////////////

   // Byte address from the fetch port
   typedef logic [31:0]  fetch_addr_t;

   // One instruction word
   typedef logic [31:0]  fetch_data_t;

   // One cache line, same as one refill beat
   typedef logic [127:0] line_t;

   // Word position inside a line
   typedef logic [1:0]   word_sel_t;

   //////////////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////////////

   // Byte offset bits below the set index (16-byte line)
   localparam int unsigned LINE_OFFSET_BITS = 4;

   // Default associativity
   localparam int unsigned DEFAULT_NB_WAYS  = 2;

   // Default number of sets
   localparam int unsigned DEFAULT_NB_SETS  = 16;

endpackage

// ==== design/icache_ctrl_pkg.sv ====
/*
 * Control encodings for the resolve stage.
 * The word selection constants assume four 32-bit words per line.
 */

package icache_ctrl_pkg;

   // Resolve stage FSM
   typedef enum logic [2:0] {
      RUN,
      REFILL_REQ,
      REFILL_WAIT,
      REFILL_WRITE,
      FLUSH
   } resolve_state_t;

   //////////////////////////////////////////////////////////
   // Refill word extraction
   //////////////////////////////////////////////////////////

   // Lowest address bit of the word select field
   localparam int unsigned WORD_SEL_LSB   = 2;

   // Words carried by one refill beat
   localparam int unsigned WORDS_PER_LINE = 4;

endpackage

// ==== design/icache_data_array.sv ====
/*
 * Line storage, one 128-bit line per way and set.
 * All ways of a set are read together, one cycle after rd_en_i.
 * Contents are undefined until written by a refill.
 */

`timescale 1ns/1ps

module icache_data_array
   import icache_cfg_pkg::*;
#(
   parameter int unsigned NB_WAYS = DEFAULT_NB_WAYS,
   parameter int unsigned NB_SETS = DEFAULT_NB_SETS,
   localparam int unsigned IDX_W  = $clog2(NB_SETS),
   localparam int unsigned WAY_W  = $clog2(NB_WAYS)
) (
   input  logic                clk,

   input  logic                rd_en_i,
   input  logic [IDX_W-1:0]    rd_index_i,
   output line_t [NB_WAYS-1:0] rd_line_o,

   input  logic                wr_en_i,
   input  logic [WAY_W-1:0]    wr_way_i,
   input  logic [IDX_W-1:0]    wr_index_i,
   input  line_t               wr_line_i
);

   line_t line_mem [NB_WAYS][NB_SETS];

   always_ff @(posedge clk) begin
      // Read every way of the set for the tag compare
      if (rd_en_i) begin
         for (int w = 0; w < NB_WAYS; w++) begin
            rd_line_o[w] <= line_mem[w][rd_index_i];
         end
      end
      // Whole line per refill
      if (wr_en_i) begin
         line_mem[wr_way_i][wr_index_i] <= wr_line_i;
      end
   end

endmodule

// ==== design/icache_tag_array.sv ====
/*
 * Tag and valid storage, one entry per way and set.
 * Reads are registered and data appears one cycle after rd_en_i. A same-edge write is not seen.
 * Reset and flush clear every valid bit in one cycle. Tag contents are kept.
 */

`timescale 1ns/1ps

module icache_tag_array
   import icache_cfg_pkg::*;
#(
   parameter int unsigned NB_WAYS = DEFAULT_NB_WAYS,
   parameter int unsigned NB_SETS = DEFAULT_NB_SETS,
   localparam int unsigned IDX_W  = $clog2(NB_SETS),
   localparam int unsigned TAG_W  = $bits(fetch_addr_t) - LINE_OFFSET_BITS - IDX_W,
   localparam int unsigned WAY_W  = $clog2(NB_WAYS)
) (
   input  logic                          clk,
   input  logic                          rst_n,

   input  logic                          rd_en_i,
   input  logic [IDX_W-1:0]              rd_index_i,
   output logic [NB_WAYS-1:0][TAG_W-1:0] rd_tag_o,
   output logic [NB_WAYS-1:0]            rd_valid_o,

   input  logic                          wr_en_i,
   input  logic [WAY_W-1:0]              wr_way_i,
   input  logic [IDX_W-1:0]              wr_index_i,
   input  logic [TAG_W-1:0]              wr_tag_i,

   input  logic                          flush_i
);

   logic [TAG_W-1:0]                  tag_mem [NB_WAYS][NB_SETS];
   logic [NB_WAYS-1:0][NB_SETS-1:0]   valid_q;

   //////////////////////////////////////////////////////////
   // Valid bits
   //////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q    <= '0;
         rd_valid_o <= '0;
      end else begin
         if (rd_en_i) begin
            for (int w = 0; w < NB_WAYS; w++) begin
               rd_valid_o[w] <= valid_q[w][rd_index_i];
            end
         end
         // Flush wins over a refill in the same cycle
         if (flush_i) begin
            valid_q <= '0;
         end else if (wr_en_i) begin
            valid_q[wr_way_i][wr_index_i] <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////
   // Tag storage
   //////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         for (int w = 0; w < NB_WAYS; w++) begin
            rd_tag_o[w] <= tag_mem[w][rd_index_i];
         end
      end
      if (wr_en_i) begin
         tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
      end
   end

endmodule

// ==== design/icache_lookup_stage.sv ====
/*
 * First pipeline stage. It grants fetches and issues the array read at the grant edge.
 * Under stall it holds its item and grants nothing. Replay rereads the held item's set.
 */

`timescale 1ns/1ps

module icache_lookup_stage
   import icache_cfg_pkg::*;
#(
   parameter int unsigned NB_WAYS = DEFAULT_NB_WAYS,
   parameter int unsigned NB_SETS = DEFAULT_NB_SETS,
   localparam int unsigned IDX_W  = $clog2(NB_SETS)
) (
   input  logic             clk,
   input  logic             rst_n,

   input  logic             fetch_req_i,
   input  fetch_addr_t      fetch_addr_i,
   output logic             fetch_gnt_o,

   // From the resolve stage
   input  logic             stall_i,
   input  logic             replay_i,

   // Array read port
   output logic             rd_en_o,
   output logic [IDX_W-1:0] rd_index_o,

   // Held item towards the resolve stage
   output logic             lookup_valid_o,
   output fetch_addr_t      lookup_addr_o
);

   logic        valid_q;
   fetch_addr_t addr_q;

   // Geometry limits, caught at elaboration
   if (NB_WAYS != 2 && NB_WAYS != 4) begin : g_bad_ways
      $error("icache: NB_WAYS must be 2 or 4");
   end
   if (NB_SETS < 2 || (NB_SETS & (NB_SETS - 1)) != 0) begin : g_bad_sets
      $error("icache: NB_SETS must be a power of two");
   end

   assign fetch_gnt_o = fetch_req_i & ~stall_i;

   // Grant reads the incoming set, replay the held one
   assign rd_en_o    = fetch_gnt_o | replay_i;
   assign rd_index_o = replay_i ? addr_q[LINE_OFFSET_BITS +: IDX_W]
                                : fetch_addr_i[LINE_OFFSET_BITS +: IDX_W];

   // Item slot empties whenever nothing is granted and no stall holds it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (!stall_i) begin
         valid_q <= fetch_gnt_o;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_gnt_o) begin
         addr_q <= fetch_addr_i;
      end
   end

   assign lookup_valid_o = valid_q;
   assign lookup_addr_o  = addr_q;

endmodule

// ==== design/icache_resolve_stage.sv ====
/*
 * Second pipeline stage: tag compare, response register, refill and flush control.
 * One refill is outstanding at a time. The victim way comes from a round-robin counter.
 * After a refill write or a flush the held lookup item is replayed before it is resolved.
 */

`timescale 1ns/1ps

module icache_resolve_stage
   import icache_cfg_pkg::*, icache_ctrl_pkg::*;
#(
   parameter int unsigned NB_WAYS = DEFAULT_NB_WAYS,
   parameter int unsigned NB_SETS = DEFAULT_NB_SETS,
   localparam int unsigned IDX_W  = $clog2(NB_SETS),
   localparam int unsigned TAG_W  = $bits(fetch_addr_t) - LINE_OFFSET_BITS - IDX_W,
   localparam int unsigned WAY_W  = $clog2(NB_WAYS)
) (
   input  logic                          clk,
   input  logic                          rst_n,

   // Lookup item and array read data
   input  logic                          lookup_valid_i,
   input  fetch_addr_t                   lookup_addr_i,
   input  logic [NB_WAYS-1:0][TAG_W-1:0] rd_tag_i,
   input  logic [NB_WAYS-1:0]            rd_valid_i,
   input  line_t [NB_WAYS-1:0]           rd_line_i,

   output logic                          fetch_rvalid_o,
   output fetch_data_t                   fetch_rdata_o,
   output logic                          stall_o,
   output logic                          replay_o,

   // L2 refill port
   output logic                          refill_req_o,
   input  logic                          refill_gnt_i,
   output fetch_addr_t                   refill_addr_o,
   input  logic                          refill_r_valid_i,
   input  line_t                         refill_r_data_i,

   // Array write port
   output logic                          wr_en_o,
   output logic [WAY_W-1:0]              wr_way_o,
   output logic [IDX_W-1:0]              wr_index_o,
   output logic [TAG_W-1:0]              wr_tag_o,
   output line_t                         wr_line_o,

   input  logic                          flush_icache_i,
   output logic                          flush_o,
   output logic                          cache_is_flushed_o
);

   resolve_state_t   state_q;
   resolve_state_t   state_d;
   logic             flush_pend_q;
   logic             replay_q;
   logic             flushed_q;
   logic             refill_valid_q;
   line_t            refill_line_q;
   logic [WAY_W-1:0] victim_q;

   logic [NB_WAYS-1:0] hit_way;
   logic               hit;
   line_t              hit_line;
   logic [TAG_W-1:0]   lookup_tag;
   logic [IDX_W-1:0]   lookup_index;
   word_sel_t          word_sel;
   logic               rvalid_d;
   fetch_data_t        rdata_d;

   // Word of a line at a given position
   function automatic fetch_data_t pick_word(line_t line_v, word_sel_t sel);
      fetch_data_t word;
      word = '0;
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
         if (sel == word_sel_t'(i)) begin
            word = line_v[i*$bits(fetch_data_t) +: $bits(fetch_data_t)];
         end
      end
      return word;
   endfunction

   // Address fields of the held item
   assign lookup_index = lookup_addr_i[LINE_OFFSET_BITS +: IDX_W];
   assign lookup_tag   = lookup_addr_i[LINE_OFFSET_BITS + IDX_W +: TAG_W];
   assign word_sel     = lookup_addr_i[WORD_SEL_LSB +: $bits(word_sel_t)];

   //////////////////////////////////////////////////////////
   // Tag compare
   //////////////////////////////////////////////////////////

   always_comb begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++) begin
         hit_way[w] = rd_valid_i[w] && (rd_tag_i[w] == lookup_tag);
         // At most one way hits, so an OR merge selects it
         if (hit_way[w]) begin
            hit_line = hit_line | rd_line_i[w];
         end
      end
      hit = |hit_way;
   end

   //////////////////////////////////////////////////////////
   // Resolve FSM
   //////////////////////////////////////////////////////////

   always_comb begin
      state_d      = state_q;
      stall_o      = 1'b0;
      replay_o     = 1'b0;
      refill_req_o = 1'b0;
      wr_en_o      = 1'b0;
      flush_o      = 1'b0;
      rvalid_d     = 1'b0;
      rdata_d      = pick_word(hit_line, word_sel);
      case (state_q)
         RUN: begin
            if (flush_pend_q) begin
               // Hold the item, its read data goes stale at the flush
               stall_o = 1'b1;
               state_d = FLUSH;
            end else if (replay_q) begin
               stall_o  = 1'b1;
               replay_o = 1'b1;
            end else if (lookup_valid_i && !hit) begin
               stall_o = 1'b1;
               state_d = REFILL_REQ;
            end else begin
               rvalid_d = lookup_valid_i;
            end
         end
         REFILL_REQ: begin
            stall_o      = 1'b1;
            refill_req_o = 1'b1;
            if (refill_gnt_i) begin
               state_d = REFILL_WAIT;
            end
         end
         REFILL_WAIT: begin
            stall_o = 1'b1;
            if (refill_valid_q) begin
               state_d = REFILL_WRITE;
            end
         end
         REFILL_WRITE: begin
            // Answer from the captured line and release the lookup stage
            wr_en_o  = 1'b1;
            rvalid_d = 1'b1;
            rdata_d  = pick_word(refill_line_q, word_sel);
            state_d  = RUN;
         end
         FLUSH: begin
            stall_o = 1'b1;
            flush_o = 1'b1;
            state_d = RUN;
         end
         default: begin
            state_d = RUN;
         end
      endcase
   end

   // Held item stays stable through the miss
   assign refill_addr_o = {lookup_addr_i[$bits(fetch_addr_t)-1:LINE_OFFSET_BITS],
                           {LINE_OFFSET_BITS{1'b0}}};

   assign wr_way_o   = victim_q;
   assign wr_index_o = lookup_index;
   assign wr_tag_o   = lookup_tag;
   assign wr_line_o  = refill_line_q;

   assign cache_is_flushed_o = flushed_q;

   //////////////////////////////////////////////////////////
   // State registers
   //////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q        <= RUN;
         flush_pend_q   <= 1'b0;
         replay_q       <= 1'b0;
         flushed_q      <= 1'b0;
         refill_valid_q <= 1'b0;
         victim_q       <= '0;
         fetch_rvalid_o <= 1'b0;
      end else begin
         state_q        <= state_d;
         replay_q       <= (state_q == REFILL_WRITE) || (state_q == FLUSH);
         refill_valid_q <= refill_r_valid_i;
         fetch_rvalid_o <= rvalid_d;
         // A pulse seen during the FLUSH cycle starts another flush
         if (state_q == FLUSH) begin
            flush_pend_q <= flush_icache_i;
         end else if (flush_icache_i) begin
            flush_pend_q <= 1'b1;
         end
         if (state_q == FLUSH) begin
            flushed_q <= 1'b1;
         end else if (state_q == REFILL_WRITE) begin
            flushed_q <= 1'b0;
         end
         // Round-robin victim, moves on every line write
         if (state_q == REFILL_WRITE) begin
            victim_q <= victim_q + 1'b1;
         end
      end
   end

   // Refill beat and response word
   always_ff @(posedge clk) begin
      if (refill_r_valid_i) begin
         refill_line_q <= refill_r_data_i;
      end
      if (rvalid_d) begin
         fetch_rdata_o <= rdata_d;
      end
   end

endmodule

// ==== design/icache_top.sv ====
/*
 * Private instruction cache with a two-stage lookup pipeline.
 * NB_SETS must be a power of two and NB_WAYS must be 2 or 4.
 * Hits answer two edges after the grant. A miss blocks further grants until the refill ends.
 */

`timescale 1ns/1ps

module icache_top
   import icache_cfg_pkg::*;
#(
   parameter int unsigned NB_WAYS = DEFAULT_NB_WAYS,
   parameter int unsigned NB_SETS = DEFAULT_NB_SETS
) (
   input  logic        clk,
   input  logic        rst_n,

   // Processor fetch port
   input  logic        fetch_req_i,
   input  fetch_addr_t fetch_addr_i,
   output logic        fetch_gnt_o,
   output logic        fetch_rvalid_o,
   output fetch_data_t fetch_rdata_o,

   // Line refill port towards L2
   output logic        refill_req_o,
   input  logic        refill_gnt_i,
   output fetch_addr_t refill_addr_o,
   input  logic        refill_r_valid_i,
   input  line_t       refill_r_data_i,

   // Whole cache flush
   input  logic        flush_icache_i,
   output logic        cache_is_flushed_o
);

   localparam int unsigned IDX_W = $clog2(NB_SETS);
   localparam int unsigned TAG_W = $bits(fetch_addr_t) - LINE_OFFSET_BITS - IDX_W;
   localparam int unsigned WAY_W = $clog2(NB_WAYS);

   // Lookup stage to arrays and resolve stage
   logic                          rd_en;
   logic [IDX_W-1:0]              rd_index;
   logic                          lookup_valid;
   fetch_addr_t                   lookup_addr;

   // Array read data
   logic [NB_WAYS-1:0][TAG_W-1:0] rd_tag;
   logic [NB_WAYS-1:0]            rd_valid;
   line_t [NB_WAYS-1:0]           rd_line;

   // Resolve stage back to lookup and arrays
   logic                          stall;
   logic                          replay;
   logic                          wr_en;
   logic [WAY_W-1:0]              wr_way;
   logic [IDX_W-1:0]              wr_index;
   logic [TAG_W-1:0]              wr_tag;
   line_t                         wr_line;
   logic                          flush;

   icache_lookup_stage #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_lookup (
      .clk            (clk),
      .rst_n          (rst_n),
      .fetch_req_i    (fetch_req_i),
      .fetch_addr_i   (fetch_addr_i),
      .fetch_gnt_o    (fetch_gnt_o),
      .stall_i        (stall),
      .replay_i       (replay),
      .rd_en_o        (rd_en),
      .rd_index_o     (rd_index),
      .lookup_valid_o (lookup_valid),
      .lookup_addr_o  (lookup_addr)
   );

   icache_tag_array #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_tag_array (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en_i    (rd_en),
      .rd_index_i (rd_index),
      .rd_tag_o   (rd_tag),
      .rd_valid_o (rd_valid),
      .wr_en_i    (wr_en),
      .wr_way_i   (wr_way),
      .wr_index_i (wr_index),
      .wr_tag_i   (wr_tag),
      .flush_i    (flush)
   );

   icache_data_array #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_data_array (
      .clk        (clk),
      .rd_en_i    (rd_en),
      .rd_index_i (rd_index),
      .rd_line_o  (rd_line),
      .wr_en_i    (wr_en),
      .wr_way_i   (wr_way),
      .wr_index_i (wr_index),
      .wr_line_i  (wr_line)
   );

   icache_resolve_stage #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_resolve (
      .clk                (clk),
      .rst_n              (rst_n),
      .lookup_valid_i     (lookup_valid),
      .lookup_addr_i      (lookup_addr),
      .rd_tag_i           (rd_tag),
      .rd_valid_i         (rd_valid),
      .rd_line_i          (rd_line),
      .fetch_rvalid_o     (fetch_rvalid_o),
      .fetch_rdata_o      (fetch_rdata_o),
      .stall_o            (stall),
      .replay_o           (replay),
      .refill_req_o       (refill_req_o),
      .refill_gnt_i       (refill_gnt_i),
      .refill_addr_o      (refill_addr_o),
      .refill_r_valid_i   (refill_r_valid_i),
      .refill_r_data_i    (refill_r_data_i),
      .wr_en_o            (wr_en),
      .wr_way_o           (wr_way),
      .wr_index_o         (wr_index),
      .wr_tag_o           (wr_tag),
      .wr_line_o          (wr_line),
      .flush_icache_i     (flush_icache_i),
      .flush_o            (flush),
      .cache_is_flushed_o (cache_is_flushed_o)
   );

endmodule

// ==== sim/icache_chk.sv ====
/*
 * Protocol checks on the cache top level, bound into icache_top.
 * Port names follow the DUT ports they watch. Nothing is checked while rst_n is low.
 */

`timescale 1ns/1ps

module icache_chk
   import icache_cfg_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input logic        fetch_gnt_o,
   input logic        refill_req_o,
   input logic        refill_gnt_i,
   input fetch_addr_t refill_addr_o,
   input logic        cache_is_flushed_o
);

   ////////////////////////////////////////////////////////////
   // Fetch port
   ////////////////////////////////////////////////////////////

   // Miss blocks the fetch port
   a_no_gnt_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> !fetch_gnt_o)
      else $error("fetch_gnt_o high while refill_req_o is pending");

   ////////////////////////////////////////////////////////////
   // Refill port
   ////////////////////////////////////////////////////////////

   // Request held until granted
   a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o)
      else $error("refill_req_o dropped before refill_gnt_i");

   a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> $stable(refill_addr_o))
      else $error("refill_addr_o changed before refill_gnt_i");

   // One request per miss
   a_single_req: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && refill_gnt_i |=> !refill_req_o)
      else $error("refill_req_o high again right after its grant");

   // Flushed flag comes from the flush cycle, never from a refill
   a_flush_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cache_is_flushed_o) |-> !refill_req_o)
      else $error("cache_is_flushed_o rose during a refill request");

endmodule

// ==== sim/icache_tb.sv ====
/*
 * Testbench for the cache at its default geometry of 2 ways and 16 sets.
 * Test addresses place the set index at bits [7:4]. The L2 model serves one refill at a time.
 */

`timescale 1ns/1ps

module icache_tb
   import icache_cfg_pkg::*;
;

   localparam int NB_RANDOM  = 200;
   // About 215 fetches at up to 18 cycles per worst-case miss
   localparam int MAX_CYCLES = 4000;
   localparam int FLUSH_WAIT = 20;
   localparam int KIND_ANY   = 0;
   localparam int KIND_HIT   = 1;
   localparam int KIND_MISS  = 2;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        fetch_req;
   fetch_addr_t fetch_addr;
   logic        fetch_gnt;
   logic        fetch_rvalid;
   fetch_data_t fetch_rdata;
   logic        refill_req;
   logic        refill_gnt;
   fetch_addr_t refill_addr;
   logic        refill_r_valid;
   line_t       refill_r_data;
   logic        flush_icache;
   logic        cache_is_flushed;

   int          seed      = 26435;
   int          cycle_cnt = 0;
   int          err_cnt   = 0;
   int          fail_cnt  = 0;
   int          req_kind;
   // Granted addresses, oldest first
   fetch_addr_t exp_q [$];
   int          hit_wait    = 0;
   int          busy_tail   = 0;
   logic        refill_busy = 1'b0;
   logic        miss_armed  = 1'b0;
   logic        miss_seen   = 1'b0;

   always #2 clk = ~clk;

   icache_top u_dut (
      .clk                (clk),
      .rst_n              (rst_n),
      .fetch_req_i        (fetch_req),
      .fetch_addr_i       (fetch_addr),
      .fetch_gnt_o        (fetch_gnt),
      .fetch_rvalid_o     (fetch_rvalid),
      .fetch_rdata_o      (fetch_rdata),
      .refill_req_o       (refill_req),
      .refill_gnt_i       (refill_gnt),
      .refill_addr_o      (refill_addr),
      .refill_r_valid_i   (refill_r_valid),
      .refill_r_data_i    (refill_r_data),
      .flush_icache_i     (flush_icache),
      .cache_is_flushed_o (cache_is_flushed)
   );

   bind icache_top icache_chk u_chk (
      .clk                (clk),
      .rst_n              (rst_n),
      .fetch_gnt_o        (fetch_gnt_o),
      .refill_req_o       (refill_req_o),
      .refill_gnt_i       (refill_gnt_i),
      .refill_addr_o      (refill_addr_o),
      .cache_is_flushed_o (cache_is_flushed_o)
   );

   ////////////////////////////////////////////////////////////
   // L2 rule and test addresses
   ////////////////////////////////////////////////////////////

   // Word content is its byte address XOR a fixed pattern
   function automatic fetch_data_t expected_word(fetch_addr_t a);
      return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
   endfunction

   function automatic line_t build_line(fetch_addr_t base);
      line_t l;
      for (int i = 0; i < 4; i++) begin
         l[i*32 +: 32] = expected_word(base + fetch_addr_t'(4 * i));
      end
      return l;
   endfunction

   // Lines 0..2 share set 3, lines 3..5 share set 9
   function automatic fetch_addr_t line_addr(int k);
      fetch_addr_t set_idx;
      fetch_addr_t tag;
      set_idx = (k < 3) ? 32'd3 : 32'd9;
      tag     = 32'h120 + fetch_addr_t'(k % 3);
      return (tag << 8) | (set_idx << 4);
   endfunction

   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      err_cnt++;
   endtask

   task automatic count_failure(input string msg);
      $display("failure at %0t ns: %s", $time, msg);
      fail_cnt++;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus tasks, called 1 ns after a rising edge
   ////////////////////////////////////////////////////////////

   task automatic issue_fetch(input fetch_addr_t a, input int kind);
      logic granted;
      fetch_req  = 1'b1;
      fetch_addr = a;
      req_kind   = kind;
      granted    = 1'b0;
      while (!granted) begin
         @(negedge clk);
         granted = fetch_gnt;
         @(posedge clk);
         #1;
      end
      fetch_req = 1'b0;
      req_kind  = KIND_ANY;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic flush_and_wait();
      int waited;
      waited = 0;
      assert (!cache_is_flushed) else count_failure("cache_is_flushed_o high before the flush");
      flush_icache = 1'b1;
      @(posedge clk);
      #1;
      flush_icache = 1'b0;
      while (!cache_is_flushed && waited < FLUSH_WAIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      assert (cache_is_flushed) else count_failure("cache_is_flushed_o never rose after the flush");
   endtask

   // L2 model with random grant and response delays
   initial begin : l2_model
      fetch_addr_t base;
      int          delay;
      forever begin
         @(posedge clk);
         #1;
         if (rst_n && refill_req) begin
            base  = refill_addr;
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            refill_gnt = 1'b1;
            @(posedge clk);
            #1;
            refill_gnt = 1'b0;
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            refill_r_valid = 1'b1;
            refill_r_data  = build_line(base);
            @(posedge clk);
            #1;
            refill_r_valid = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks, sampled at the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin : check_outputs
      fetch_addr_t head;
      fetch_data_t want;
      if (!rst_n) begin
         assert (!fetch_gnt) else show_mismatch("fetch_gnt_o", fetch_gnt, 0);
         assert (!fetch_rvalid) else show_mismatch("fetch_rvalid_o", fetch_rvalid, 0);
         assert (!refill_req) else show_mismatch("refill_req_o", refill_req, 0);
         assert (!cache_is_flushed) else show_mismatch("cache_is_flushed_o", cache_is_flushed, 0);
      end else begin
         // Stall lasts until two cycles after the refill beat
         if (busy_tail != 0) begin
            busy_tail--;
            if (busy_tail == 0) begin
               refill_busy = 1'b0;
            end
         end
         if (refill_busy) begin
            assert (!fetch_gnt) else count_failure("fetch granted during an outstanding refill");
         end
         if (refill_r_valid) begin
            busy_tail = 2;
         end
         if (refill_req) begin
            refill_busy = 1'b1;
            miss_seen   = 1'b1;
            if (exp_q.size() == 0) begin
               count_failure("refill requested with no fetch outstanding");
            end else begin
               head = exp_q[0];
               assert (refill_addr == {head[31:4], 4'h0})
                  else show_mismatch("refill_addr_o", refill_addr, {head[31:4], 4'h0});
            end
         end
         // Hit latency from the grant
         if (hit_wait != 0) begin
            hit_wait--;
            assert (!refill_req) else count_failure("refill requested for a line that should hit");
            if (hit_wait == 0) begin
               assert (fetch_rvalid) else count_failure("hit not answered two edges after grant");
            end
         end
         if (fetch_rvalid) begin
            if (exp_q.size() == 0) begin
               count_failure("response with no fetch outstanding");
            end else begin
               head = exp_q.pop_front();
               want = expected_word(head);
               assert (fetch_rdata == want) else show_mismatch("fetch_rdata_o", fetch_rdata, want);
               if (miss_armed) begin
                  assert (miss_seen) else count_failure("fetch after flush hit without a refill");
                  miss_armed = 1'b0;
               end
            end
         end
         if (fetch_req && fetch_gnt) begin
            exp_q.push_back(fetch_addr);
            if (req_kind == KIND_HIT) begin
               hit_wait = 2;
            end
            if (req_kind == KIND_MISS) begin
               miss_armed = 1'b1;
               miss_seen  = 1'b0;
            end
         end
      end
   end

   always @(posedge clk) begin : watchdog
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      int pick;
      int word;
      int gap;
      rst_n          = 1'b0;
      fetch_req      = 1'b0;
      fetch_addr     = '0;
      req_kind       = KIND_ANY;
      refill_gnt     = 1'b0;
      refill_r_valid = 1'b0;
      refill_r_data  = '0;
      flush_icache   = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Cold miss, then a hit on the line just written
      issue_fetch(line_addr(0), KIND_MISS);
      wait_idle();
      issue_fetch(line_addr(0) + 32'h8, KIND_HIT);
      wait_idle();

      // Three lines fighting over the two ways of set 3
      for (int r = 0; r < 2; r++) begin
         for (int k = 0; k < 3; k++) begin
            issue_fetch(line_addr(k) + 32'h4, KIND_ANY);
         end
      end
      wait_idle();

      // Random mix over six lines in two sets
      for (int n = 0; n < NB_RANDOM; n++) begin
         pick = $unsigned($random(seed)) % 6;
         word = $unsigned($random(seed)) % 4;
         issue_fetch(line_addr(pick) + fetch_addr_t'(4 * word), KIND_ANY);
         gap = $unsigned($random(seed)) % 2;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
      wait_idle();

      // After a flush, earlier lines must refill
      flush_and_wait();
      issue_fetch(line_addr(0), KIND_MISS);
      wait_idle();
      issue_fetch(line_addr(4) + 32'hc, KIND_MISS);
      wait_idle();
      assert (!cache_is_flushed) else count_failure("cache_is_flushed_o stayed high after a refill");
      repeat (4) @(posedge clk);

      $display("checks done: %0d value errors, %0d other failures", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== icache.f ====
design/icache_cfg_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_data_array.sv
design/icache_tag_array.sv
design/icache_lookup_stage.sv
design/icache_resolve_stage.sv
design/icache_top.sv
sim/icache_chk.sv
sim/icache_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench
# The run passes only if the log holds the pass line

TOP := icache_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f icache.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f icache.f

clean:
	rm -rf obj_dir $(LOG)
